/* rtl/spi_burst_defs.svh */
// burst geometry is fixed at compile time; SPI_DATA_WIDTH must be at least 2
`ifndef SPI_BURST_DEFS_SVH
`define SPI_BURST_DEFS_SVH

// bits per SPI word, shifted MSB first
`define SPI_DATA_WIDTH 8

// words per burst, word 0 goes out first
`define SPI_BURST_SIZE 4

`endif

/* rtl/spi_burst_pkg.sv */
// shared types for the SPI burst master; element 0 of a burst is the first word on the wire
`include "spi_burst_defs.svh"

package spi_burst_pkg;

    localparam int word_idx_w = (`SPI_BURST_SIZE > 1) ? $clog2(`SPI_BURST_SIZE) : 1;

    typedef logic [`SPI_DATA_WIDTH-1:0] word_t;
    typedef word_t [`SPI_BURST_SIZE-1:0] burst_t;
    typedef logic [word_idx_w-1:0] word_idx_t;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_load   = 2'd1,
        st_shift  = 2'd2,
        st_finish = 2'd3
    } ctrl_state_e;

    typedef struct packed {
        logic rise;       // sclk goes high at the end of this cycle
        logic fall;       // sclk goes low at the end of this cycle
        logic word_last;  // bit 0 of the current word
        logic burst_last; // bit 0 of the last word
    } spi_tick_t;

    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

endpackage

/* rtl/spi_burst_ctrl.sv */
// burst FSM; burst_start is only honoured in idle, a start during a burst is dropped
`timescale 1ns/1ps

module spi_burst_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      burst_start,
    input  spi_burst_pkg::spi_tick_t  tick,
    output logic                      start_load,
    output logic                      active,
    output logic                      finish,
    output logic                      busy
);

    spi_burst_pkg::ctrl_state_e state;
    spi_burst_pkg::ctrl_state_e state_nxt;
    logic busy_q;

    always_comb begin
        state_nxt = state;
        case (state)
            spi_burst_pkg::st_idle: begin
                if (burst_start) begin
                    state_nxt = spi_burst_pkg::st_load;
                end
            end
            spi_burst_pkg::st_load: begin
                state_nxt = spi_burst_pkg::st_shift;
            end
            spi_burst_pkg::st_shift: begin
                // wait for the closing fall so sclk is low before cs_n rises
                if (tick.fall && tick.burst_last) begin
                    state_nxt = spi_burst_pkg::st_finish;
                end
            end
            spi_burst_pkg::st_finish: begin
                state_nxt = spi_burst_pkg::st_idle;
            end
            default: begin
                state_nxt = spi_burst_pkg::st_idle;
            end
        endcase
    end

    // outputs decoded from the next state so they line up with the state itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= spi_burst_pkg::st_idle;
            start_load <= 1'b0;
            finish     <= 1'b0;
            busy_q     <= 1'b0;
        end else begin
            state      <= state_nxt;
            start_load <= (state_nxt == spi_burst_pkg::st_load);
            finish     <= (state_nxt == spi_burst_pkg::st_finish);
            busy_q     <= (state_nxt == spi_burst_pkg::st_load) ||
                          (state_nxt == spi_burst_pkg::st_shift);
        end
    end

    assign active = busy_q;  // also drives cs_n
    assign busy   = busy_q;

endmodule

/* rtl/spi_bit_timer.sv */
// sclk runs at clk/2, mode 0 only; ticks are qualified by active and start one cycle after start_load
`timescale 1ns/1ps

module spi_bit_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_load,
    input  logic                      active,
    output spi_burst_pkg::spi_tick_t  tick,
    output spi_burst_pkg::word_idx_t  word_idx,
    output logic                      sclk
);

    localparam int data_w    = $bits(spi_burst_pkg::word_t);
    localparam int burst_n   = $bits(spi_burst_pkg::burst_t) / data_w;
    localparam int bit_cnt_w = (data_w > 1) ? $clog2(data_w) : 1;

    logic                     sclk_q;
    logic [bit_cnt_w-1:0]     bit_cnt;
    spi_burst_pkg::word_idx_t word_cnt;
    logic                     run;
    logic                     bit_last;
    logic                     word_final;

    assign run        = active & ~start_load;
    assign bit_last   = (bit_cnt == '0);
    assign word_final = (word_cnt == spi_burst_pkg::word_idx_t'(burst_n - 1));

    always_comb begin
        tick.rise       = run & ~sclk_q;
        tick.fall       = run & sclk_q;
        tick.word_last  = run & bit_last;
        tick.burst_last = run & bit_last & word_final;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q   <= 1'b0;
            bit_cnt  <= bit_cnt_w'(data_w - 1);
            word_cnt <= '0;
        end else if (start_load) begin
            sclk_q   <= 1'b0;
            bit_cnt  <= bit_cnt_w'(data_w - 1);
            word_cnt <= '0;
        end else if (run) begin
            sclk_q <= ~sclk_q;
            if (tick.fall) begin
                if (bit_last) begin
                    bit_cnt  <= bit_cnt_w'(data_w - 1);  // next word, MSB first
                    word_cnt <= word_cnt + 1'b1;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    assign sclk     = sclk_q & active;  // held low outside a burst
    assign word_idx = word_cnt;

endmodule

/* rtl/spi_shift_engine.sv */
// MSB-first shifter; mosi changes on sclk falls, miso is sampled on rises, rx_word_valid trails by a cycle
`timescale 1ns/1ps

module spi_shift_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_load,
    input  spi_burst_pkg::spi_tick_t  tick,
    input  spi_burst_pkg::word_t      tx_word,
    input  logic                      miso,
    output logic                      mosi,
    output spi_burst_pkg::word_t      rx_word,
    output logic                      rx_word_valid
);

    localparam int data_w = $bits(spi_burst_pkg::word_t);

    spi_burst_pkg::word_t tx_sr;
    spi_burst_pkg::word_t rx_sr;
    logic                 tx_reload;

    // first word at start, then the following word after each word's last fall
    assign tx_reload = start_load | (tick.fall & tick.word_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_sr <= '0;  // keeps mosi defined before the first burst
        end else if (tx_reload) begin
            tx_sr <= tx_word;
        end else if (tick.fall) begin
            tx_sr <= {tx_sr[data_w-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (tick.rise) begin
            rx_sr <= {rx_sr[data_w-2:0], miso};
        end
    end

    // high once the last bit is in rx_sr
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_word_valid <= 1'b0;
        end else begin
            rx_word_valid <= tick.rise & tick.word_last;
        end
    end

    assign mosi    = tx_sr[data_w-1];
    assign rx_word = rx_sr;

endmodule

/* rtl/spi_burst_buffer.sv */
// tx_data is sampled once per burst; rx_data is written at the clock edge that ends the burst_done cycle
`timescale 1ns/1ps

module spi_burst_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_load,
    input  spi_burst_pkg::burst_t     tx_data,
    input  spi_burst_pkg::word_idx_t  word_idx,
    input  spi_burst_pkg::word_t      rx_word,
    input  logic                      rx_word_valid,
    input  logic                      finish,
    output spi_burst_pkg::word_t      tx_word,
    output spi_burst_pkg::burst_t     rx_data
);

    localparam int burst_n = $bits(spi_burst_pkg::burst_t) / $bits(spi_burst_pkg::word_t);

    spi_burst_pkg::burst_t    tx_buf;
    spi_burst_pkg::burst_t    rx_stage;
    spi_burst_pkg::word_idx_t next_idx;
    logic                     idx_final;

    assign idx_final = (word_idx == spi_burst_pkg::word_idx_t'(burst_n - 1));
    assign next_idx  = idx_final ? '0 : word_idx + 1'b1;  // wraps for non power of 2 sizes

    // tx_buf is not loaded yet while start_load is high, so word 0 comes straight from the port
    assign tx_word = start_load ? tx_data[0] : tx_buf[next_idx];

    always_ff @(posedge clk) begin
        if (start_load) begin
            tx_buf <= tx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_word_valid) begin
            rx_stage[word_idx] <= rx_word;
        end
    end

    // rx_data holds the previous burst until finish
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_data <= '0;
        end else if (finish) begin
            rx_data <= rx_stage;
        end
    end

endmodule

/* rtl/spi_burst_top.sv */
// SPI mode 0 burst master, one chip select, fixed burst length, no back-pressure on either side
`timescale 1ns/1ps

module spi_burst_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      burst_start,
    input  spi_burst_pkg::burst_t     tx_data,
    input  logic                      miso,
    output spi_burst_pkg::burst_t     rx_data,
    output logic                      burst_done,
    output logic                      busy,
    output spi_burst_pkg::spi_pins_t  spi
);

    logic                      start_load;
    logic                      active;
    logic                      finish;
    spi_burst_pkg::spi_tick_t  tick;
    spi_burst_pkg::word_idx_t  word_idx;
    spi_burst_pkg::word_t      tx_word;
    spi_burst_pkg::word_t      rx_word;
    logic                      rx_word_valid;
    logic                      sclk;
    logic                      mosi;

    spi_burst_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .burst_start (burst_start),
        .tick        (tick),
        .start_load  (start_load),
        .active      (active),
        .finish      (finish),
        .busy        (busy)
    );

    spi_bit_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_load (start_load),
        .active     (active),
        .tick       (tick),
        .word_idx   (word_idx),
        .sclk       (sclk)
    );

    spi_shift_engine u_shift (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_load    (start_load),
        .tick          (tick),
        .tx_word       (tx_word),
        .miso          (miso),
        .mosi          (mosi),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid)
    );

    spi_burst_buffer u_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_load    (start_load),
        .tx_data       (tx_data),
        .word_idx      (word_idx),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .finish        (finish),
        .tx_word       (tx_word),
        .rx_data       (rx_data)
    );

    assign burst_done = finish;
    assign spi = '{sclk: sclk, cs_n: ~active, mosi: mosi};  // cs_n low for the whole burst

endmodule

/* testbench/tb_clk_gen.sv */
// 10 ns clock from time 0; rst_n low for the first 2 rising edges, released 1 ns after the second
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam time half_period = 5ns;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;  // same 1 ns offset as the other stimulus
    end

endmodule

/* testbench/spi_slave_model.sv */
// mode 0 SPI slave; preset must be stable at the cs_n fall, record is cleared at each cs_n fall
`timescale 1ns/1ps

module spi_slave_model (
    input  spi_burst_pkg::spi_pins_t spi,
    input  spi_burst_pkg::burst_t    preset,
    output logic                     miso,
    output spi_burst_pkg::burst_t    received,
    output int                       rx_bits
);

    localparam int data_w  = $bits(spi_burst_pkg::word_t);
    localparam int burst_n = $bits(spi_burst_pkg::burst_t) / data_w;

    logic                  sclk;
    logic                  cs_n;
    logic                  mosi;
    logic                  sclk_q;
    logic                  cs_n_q;
    spi_burst_pkg::burst_t tx_left;
    spi_burst_pkg::word_t  tx_cur;
    spi_burst_pkg::word_t  rx_cur;
    int                    tx_pos;

    assign sclk = spi.sclk;
    assign cs_n = spi.cs_n;
    assign mosi = spi.mosi;

    initial begin
        miso     = 1'b0;
        received = '0;
        rx_bits  = 0;
        sclk_q   = 1'b0;
        cs_n_q   = 1'b1;
        tx_left  = '0;
        tx_cur   = '0;
        rx_cur   = '0;
        tx_pos   = 0;
        forever begin
            @(sclk or cs_n);
            if (cs_n_q && !cs_n) begin
                tx_left  = preset;
                tx_cur   = preset[0];
                tx_pos   = 0;
                rx_bits  = 0;
                received = '0;
                miso     = preset[0][data_w-1];  // first bit ready before the first rise
            end else if (!sclk_q && sclk && !cs_n) begin
                rx_cur  = {rx_cur[data_w-2:0], mosi};
                rx_bits = rx_bits + 1;
                if (rx_bits % data_w == 0) begin
                    received = {rx_cur, received[burst_n-1:1]};  // word 0 ends up at index 0
                end
            end else if (sclk_q && !sclk) begin
                tx_pos = tx_pos + 1;
                if (tx_pos == data_w) begin
                    tx_pos  = 0;
                    tx_left = tx_left >> data_w;
                    tx_cur  = tx_left[0];
                end else begin
                    tx_cur = tx_cur << 1;
                end
                miso = tx_cur[data_w-1];
            end
            sclk_q = sclk;
            cs_n_q = cs_n;
        end
    end

endmodule

/* testbench/tb_spi_burst.sv */
// directed tests for spi_burst_top; needs SPI_BURST_SIZE >= 2 and SPI_DATA_WIDTH <= 32
`timescale 1ns/1ps
`include "spi_burst_defs.svh"

module tb_spi_burst;

    localparam int data_w       = `SPI_DATA_WIDTH;
    localparam int burst_n      = `SPI_BURST_SIZE;
    localparam int total_bits   = data_w * burst_n;
    localparam int done_latency = 1 + 2 * total_bits;  // load cycle, 2 clk per bit
    localparam int wait_limit   = 2 * done_latency + 16;
    localparam int check_w      = ($bits(spi_burst_pkg::burst_t) > 32) ?
                                  $bits(spi_burst_pkg::burst_t) : 32;

    typedef logic [check_w-1:0] vec_t;

    logic                     clk;
    logic                     rst_n;
    logic                     burst_start;
    spi_burst_pkg::burst_t    tx_data;
    logic                     miso;
    spi_burst_pkg::burst_t    rx_data;
    logic                     burst_done;
    logic                     busy;
    spi_burst_pkg::spi_pins_t spi;
    spi_burst_pkg::burst_t    slave_preset;
    spi_burst_pkg::burst_t    slave_record;
    int                       slave_bits;
    spi_burst_pkg::burst_t    last_rx;
    logic [31:0]              rng_state;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    spi_burst_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .burst_start (burst_start),
        .tx_data     (tx_data),
        .miso        (miso),
        .rx_data     (rx_data),
        .burst_done  (burst_done),
        .busy        (busy),
        .spi         (spi)
    );

    spi_slave_model u_slave (
        .spi      (spi),
        .preset   (slave_preset),
        .miso     (miso),
        .received (slave_record),
        .rx_bits  (slave_bits)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input vec_t actual, input vec_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_burst(output spi_burst_pkg::burst_t words);
        words = '0;
        for (int i = 0; i < burst_n; i++) begin
            rng_state = xorshift32(rng_state);
            words = {spi_burst_pkg::word_t'(rng_state), words[burst_n-1:1]};
        end
    endtask

    // entered 1 ns after an edge, returns 1 ns after the edge that sampled burst_start
    task automatic start_burst(input spi_burst_pkg::burst_t words,
                               input spi_burst_pkg::burst_t slave_words);
        tx_data      = words;
        slave_preset = slave_words;
        burst_start  = 1'b1;
        @(posedge clk);
        #1 burst_start = 1'b0;
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (burst_done !== 1'b1) begin
            check_equal("spi.cs_n", vec_t'(spi.cs_n), vec_t'(0));  // low for the whole burst
            check_equal("busy", vec_t'(busy), vec_t'(1));
            check_equal("rx_data (held)", vec_t'(rx_data), vec_t'(last_rx));
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                abort_run($sformatf("timeout: no burst_done within %0d cycles", wait_limit));
            end
        end
    endtask

    // called in the burst_done cycle
    task automatic close_burst(input spi_burst_pkg::burst_t exp_rx,
                               input spi_burst_pkg::burst_t exp_tx);
        check_equal("rx_data (held)", vec_t'(rx_data), vec_t'(last_rx));
        check_equal("spi.cs_n", vec_t'(spi.cs_n), vec_t'(1));
        check_equal("spi.sclk", vec_t'(spi.sclk), vec_t'(0));
        check_equal("busy", vec_t'(busy), vec_t'(0));
        @(posedge clk);
        #1;
        check_equal("burst_done", vec_t'(burst_done), vec_t'(0));  // single cycle pulse
        check_equal("rx_data", vec_t'(rx_data), vec_t'(exp_rx));
        check_equal("slave mosi words", vec_t'(slave_record), vec_t'(exp_tx));
        check_equal("slave bit count", vec_t'(slave_bits), vec_t'(total_bits));
        last_rx = exp_rx;
    endtask

    task automatic reset_values();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 16) begin
                abort_run("timeout: reset was never released");
            end
        end
        @(posedge clk);
        #1;
        check_equal("spi.sclk", vec_t'(spi.sclk), vec_t'(0));
        check_equal("spi.cs_n", vec_t'(spi.cs_n), vec_t'(1));
        check_equal("burst_done", vec_t'(burst_done), vec_t'(0));
        check_equal("busy", vec_t'(busy), vec_t'(0));
        check_equal("rx_data", vec_t'(rx_data), vec_t'(0));
    endtask

    task automatic fixed_pattern();
        spi_burst_pkg::burst_t tx_words;
        spi_burst_pkg::burst_t sl_words;
        int cycles;
        tx_words = '0;
        sl_words = '0;
        for (int i = 0; i < burst_n; i++) begin
            tx_words = {spi_burst_pkg::word_t'(32'h5a + 32'h21 * i), tx_words[burst_n-1:1]};
            sl_words = {spi_burst_pkg::word_t'(32'hc3 + 32'h1e * i), sl_words[burst_n-1:1]};
        end
        start_burst(tx_words, sl_words);
        wait_done(cycles);
        close_burst(sl_words, tx_words);
    endtask

    task automatic latency_and_cs();
        spi_burst_pkg::burst_t tx_words;
        spi_burst_pkg::burst_t sl_words;
        int cycles;
        draw_burst(tx_words);
        draw_burst(sl_words);
        start_burst(tx_words, sl_words);
        wait_done(cycles);
        check_equal("burst_done latency", vec_t'(cycles), vec_t'(done_latency));
        close_burst(sl_words, tx_words);
    endtask

    task automatic start_isolation();
        spi_burst_pkg::burst_t tx_words;
        spi_burst_pkg::burst_t sl_words;
        int cycles;
        draw_burst(tx_words);
        draw_burst(sl_words);
        start_burst(tx_words, sl_words);
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #1;
        end
        tx_data     = ~tx_words;  // must not reach the wire
        burst_start = 1'b1;
        @(posedge clk);
        #1 burst_start = 1'b0;
        wait_done(cycles);
        close_burst(sl_words, tx_words);
        for (int i = 0; i < done_latency + 4; i++) begin
            check_equal("burst_done (extra)", vec_t'(burst_done), vec_t'(0));
            check_equal("busy (extra)", vec_t'(busy), vec_t'(0));
            @(posedge clk);
            #1;
        end
    endtask

    task automatic random_bursts();
        spi_burst_pkg::burst_t tx_words;
        spi_burst_pkg::burst_t sl_words;
        int cycles;
        for (int b = 0; b < 6; b++) begin
            draw_burst(tx_words);
            draw_burst(sl_words);
            start_burst(tx_words, sl_words);  // right after the previous burst_done
            wait_done(cycles);
            check_equal("burst_done latency", vec_t'(cycles), vec_t'(done_latency));
            close_burst(sl_words, tx_words);
        end
    endtask

    initial begin
        burst_start  = 1'b0;
        tx_data      = '0;
        slave_preset = '0;
        last_rx      = '0;
        rng_state    = 32'h1f44_3db0;
        reset_values();
        fixed_pattern();
        latency_and_cs();
        start_isolation();
        random_bursts();
        $display("sim passed");
        $finish;
    end

endmodule

/* spi_burst.f */
+incdir+rtl
rtl/spi_burst_pkg.sv
rtl/spi_burst_ctrl.sv
rtl/spi_bit_timer.sv
rtl/spi_shift_engine.sv
rtl/spi_burst_buffer.sv
rtl/spi_burst_top.sv
testbench/tb_clk_gen.sv
testbench/spi_slave_model.sv
testbench/tb_spi_burst.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_burst
FILELIST  ?= spi_burst.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
